// File: dv/seed_queue_properties.sv
module seed_queue_properties import seed_queue_pkg::*; (
	input logic             Clk_32UI,
	input logic             reset_n,
	input logic             stall,
	input logic             new_read,
	input logic             occ_valid,
	input logic             ring_pop,
	input logic             occ_pop,
	input task_status_e     head_status,
	input task_status_e     out_status,
	input logic [POS_W-1:0] out_ptr_curr,
	input logic [POS_W-1:0] out_forward_i,
	input logic [POS_W-1:0] new_forward_i
);
	timeunit 1ns;
	timeprecision 1ps;

	int assert_fails = 0;	// summed into the closing count

	// ==================================================
	// new-read handshake
	// ==================================================
	new_read_gated: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		new_read |-> (!stall && !occ_valid))
	else begin
		$error("new_read high while stalled or with a count response waiting");
		assert_fails++;
	end

	// init task built from the read offered one cycle earlier
	init_fields: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		new_read |=> (out_status == F_INIT && out_ptr_curr == '0
			&& out_forward_i == POS_W'($past(new_forward_i) + 1'b1)))
	else begin
		$error("init task emitted with wrong ptr_curr or forward_i");
		assert_fails++;
	end

	// ==================================================
	// output register behavior
	// ==================================================
	stall_hold: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		stall |=> $stable(out_status))
	else begin
		$error("out_status changed while stall was high");
		assert_fails++;
	end

	reset_bubble: assert property (@(posedge Clk_32UI)
		!reset_n |=> (out_status == BUBBLE))
	else begin
		$error("out_status not BUBBLE during reset");
		assert_fails++;
	end

	// a break task never consumes a count response
	break_no_occ: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		(ring_pop && head_status == F_BREAK) |-> !occ_pop)
	else begin
		$error("count FIFO popped together with a break task");
		assert_fails++;
	end

endmodule

// File: dv/seed_queue_tb.sv
module seed_queue_tb import seed_queue_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		task_status_e          status;
		logic [POS_W-1:0]      ptr_curr;
		logic [READ_NUM_W-1:0] read_num;
		logic [INTV_W-1:0]     ik_x0;
		logic [INTV_W-1:0]     ik_x1;
		logic [INTV_W-1:0]     ik_x2;
		logic [INFO_W-1:0]     ik_info;
		logic [POS_W-1:0]      forward_i;
		logic [POS_W-1:0]      min_intv;
		logic [POS_W-1:0]      backward_x;
		logic [POS_W-1:0]      qpos;	// query address
		logic [READ_NUM_W-1:0] qread;
	} task_rec_t;

	logic                  Clk_32UI;
	logic                  reset_n;
	logic                  stall;
	task_status_e          in_status;
	logic [POS_W-1:0]      ptr_curr;
	logic [READ_NUM_W-1:0] read_num;
	logic [INTV_W-1:0]     ik_x0;
	logic [INTV_W-1:0]     ik_x1;
	logic [INTV_W-1:0]     ik_x2;
	logic [INFO_W-1:0]     ik_info;
	logic [POS_W-1:0]      forward_i;
	logic [POS_W-1:0]      min_intv;
	logic [POS_W-1:0]      backward_x;
	logic [POS_W-1:0]      next_query_position;
	logic [READ_NUM_W-1:0] read_num_query;
	logic [POS_W-1:0]      query_position;
	logic [READ_NUM_W-1:0] query_read_num;
	logic [BASE_W-1:0]     query_base = '0;
	logic                  dram_get;
	logic [OCC_WORD_W-1:0] occ_a0;
	logic [OCC_WORD_W-1:0] occ_a1;
	logic [OCC_WORD_W-1:0] occ_a2;
	logic [OCC_WORD_W-1:0] occ_a3;
	logic                  new_read;
	logic                  new_read_valid;
	logic [READ_NUM_W-1:0] new_read_num;
	logic [INTV_W-1:0]     new_ik_x0;
	logic [INTV_W-1:0]     new_ik_x1;
	logic [INTV_W-1:0]     new_ik_x2;
	logic [INFO_W-1:0]     new_ik_info;
	logic [POS_W-1:0]      new_forward_i;
	logic [POS_W-1:0]      new_min_intv;
	task_status_e          out_status;
	logic [POS_W-1:0]      out_ptr_curr;
	logic [READ_NUM_W-1:0] out_read_num;
	logic [INTV_W-1:0]     out_ik_x0;
	logic [INTV_W-1:0]     out_ik_x1;
	logic [INTV_W-1:0]     out_ik_x2;
	logic [INFO_W-1:0]     out_ik_info;
	logic [POS_W-1:0]      out_forward_i;
	logic [POS_W-1:0]      out_min_intv;
	logic [POS_W-1:0]      out_backward_x;
	logic [BASE_W-1:0]     out_query;
	logic [OCC_WORD_W-1:0] out_occ0;
	logic [OCC_WORD_W-1:0] out_occ1;
	logic [OCC_WORD_W-1:0] out_occ2;
	logic [OCC_WORD_W-1:0] out_occ3;

	logic [BASE_W-1:0] ram_mem [1<<READ_NUM_W][1<<POS_W];	// read-base RAM contents
	logic [BASE_W-1:0] base_pipe0 = '0;
	logic [BASE_W-1:0] base_pipe1 = '0;
	int errors = 0;
	int checks = 0;
	int tests = 0;

	seed_queue_top dut (.*);

	bind seed_queue_top seed_queue_properties u_props (
		.Clk_32UI      (Clk_32UI),
		.reset_n       (reset_n),
		.stall         (stall),
		.new_read      (new_read),
		.occ_valid     (occ_valid),
		.ring_pop      (ring_pop),
		.occ_pop       (occ_pop),
		.head_status   (head_status),
		.out_status    (out_status),
		.out_ptr_curr  (out_ptr_curr),
		.out_forward_i (out_forward_i),
		.new_forward_i (new_forward_i)
	);

	initial begin
		Clk_32UI = 1'b0;
		forever #2 Clk_32UI = ~Clk_32UI;
	end

	// RAM model, base appears QUERY_LAT unstalled cycles after the address
	always @(posedge Clk_32UI) begin
		if (!stall) begin
			base_pipe0 <= ram_mem[query_read_num][query_position];
			base_pipe1 <= base_pipe0;
			query_base <= base_pipe1;
		end
	end

	// ==================================================
	// helpers
	// ==================================================
	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	function automatic task_rec_t random_task(input task_status_e st);
		task_rec_t t;
		t.status     = st;
		t.ptr_curr   = POS_W'($urandom);
		t.read_num   = READ_NUM_W'($urandom);
		t.ik_x0      = INTV_W'($urandom);
		t.ik_x1      = INTV_W'($urandom);
		t.ik_x2      = INTV_W'($urandom);
		t.ik_info    = INFO_W'($urandom);
		t.forward_i  = POS_W'($urandom);
		t.min_intv   = POS_W'($urandom);
		t.backward_x = POS_W'($urandom);
		t.qpos       = POS_W'($urandom);
		t.qread      = READ_NUM_W'($urandom);
		return t;
	endfunction

	task automatic submit(input task_rec_t t);
		@(posedge Clk_32UI);
		in_status           <= t.status;
		ptr_curr            <= t.ptr_curr;
		read_num            <= t.read_num;
		ik_x0               <= t.ik_x0;
		ik_x1               <= t.ik_x1;
		ik_x2               <= t.ik_x2;
		ik_info             <= t.ik_info;
		forward_i           <= t.forward_i;
		min_intv            <= t.min_intv;
		backward_x          <= t.backward_x;
		next_query_position <= t.qpos;
		read_num_query      <= t.qread;
	endtask

	task automatic submit_done();
		@(posedge Clk_32UI);
		in_status <= BUBBLE;
	endtask

	// one DRAM pulse, words returned as {a0, a1, a2, a3}
	task automatic send_rsp(output logic [OCC_WORDS*OCC_WORD_W-1:0] rsp);
		rsp[127:96] = $urandom;
		rsp[95:64]  = $urandom;
		rsp[63:32]  = $urandom;
		rsp[31:0]   = $urandom;
		@(posedge Clk_32UI);
		dram_get <= 1'b1;
		occ_a0   <= rsp[127:96];
		occ_a1   <= rsp[95:64];
		occ_a2   <= rsp[63:32];
		occ_a3   <= rsp[31:0];
		@(posedge Clk_32UI);
		dram_get <= 1'b0;
	endtask

	task automatic wait_out(input string what, input int limit);
		int n;
		n = 0;
		do begin
			@(negedge Clk_32UI);
			n++;
		end while (out_status == BUBBLE && n < limit);
		if (out_status == BUBBLE) begin
			$display("timeout: no task emitted while waiting for %s", what);
			errors++;
		end
	endtask

	task automatic wait_new_read(input int limit);
		int n;
		n = 0;
		do begin
			@(negedge Clk_32UI);
			n++;
		end while (!new_read && n < limit);
		if (!new_read) begin
			$display("timeout: new_read never rose with both queues empty");
			errors++;
		end
	endtask

	task automatic check_task(input task_rec_t t, input logic [BASE_W-1:0] base,
		input logic [OCC_WORDS*OCC_WORD_W-1:0] rsp, input bit counted);
		check_val("out_status", 64'(out_status), 64'(t.status));
		check_val("out_ptr_curr", 64'(out_ptr_curr), 64'(t.ptr_curr));
		check_val("out_read_num", 64'(out_read_num), 64'(t.read_num));
		check_val("out_ik_x0", 64'(out_ik_x0), 64'(t.ik_x0));
		check_val("out_ik_x1", 64'(out_ik_x1), 64'(t.ik_x1));
		check_val("out_ik_x2", 64'(out_ik_x2), 64'(t.ik_x2));
		check_val("out_ik_info", 64'(out_ik_info), 64'(t.ik_info));
		check_val("out_forward_i", 64'(out_forward_i), 64'(t.forward_i));
		check_val("out_min_intv", 64'(out_min_intv), 64'(t.min_intv));
		check_val("out_backward_x", 64'(out_backward_x), 64'(t.backward_x));
		check_val("out_query", 64'(out_query), 64'(base));
		if (counted) begin
			check_val("out_occ0", 64'(out_occ0), 64'(rsp[127:96]));
			check_val("out_occ1", 64'(out_occ1), 64'(rsp[95:64]));
			check_val("out_occ2", 64'(out_occ2), 64'(rsp[63:32]));
			check_val("out_occ3", 64'(out_occ3), 64'(rsp[31:0]));
		end
	endtask

	task automatic report_test(input string name, input int start);
		tests++;
		if (errors == start) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - start);
		end
	endtask

	// ==================================================
	// tests
	// ==================================================
	task automatic test_reset();
		int start;
		start = errors;
		repeat (5) begin
			@(negedge Clk_32UI);
			check_val("out_status", 64'(out_status), 64'(BUBBLE));
			check_val("new_read", 64'(new_read), 64'(1'b0));
		end
		report_test("reset", start);
	endtask

	task automatic test_new_read();
		int start;
		task_rec_t n;
		task_rec_t e;
		start = errors;
		n = random_task(F_INIT);
		@(posedge Clk_32UI);
		new_read_valid <= 1'b1;
		new_read_num   <= n.read_num;
		new_ik_x0      <= n.ik_x0;
		new_ik_x1      <= n.ik_x1;
		new_ik_x2      <= n.ik_x2;
		new_ik_info    <= n.ik_info;
		new_forward_i  <= n.forward_i;
		new_min_intv   <= n.min_intv;
		wait_new_read(20);
		@(posedge Clk_32UI);
		new_read_valid <= 1'b0;
		e = n;
		e.ptr_curr   = '0;
		e.forward_i  = POS_W'(n.forward_i + 1'b1);
		e.backward_x = n.forward_i;
		wait_out("init task", 20);
		check_task(e, '0, '0, 1'b0);
		report_test("new read", start);
	endtask

	task automatic test_break();
		int start;
		task_rec_t b;
		task_rec_t r;
		logic [OCC_WORDS*OCC_WORD_W-1:0] rr;
		start = errors;
		b = random_task(F_BREAK);
		r = random_task(F_RUN);
		send_rsp(rr);	// response waits while the break passes
		submit(b);
		submit_done();
		wait_out("break task", 40);
		check_task(b, ram_mem[b.qread][b.qpos], '0, 1'b0);
		submit(r);
		submit_done();
		wait_out("task after break", 40);
		check_task(r, ram_mem[r.qread][r.qpos], rr, 1'b1);
		report_test("break task", start);
	endtask

	task automatic test_counted();
		int start;
		task_rec_t a;
		task_rec_t b;
		task_rec_t c;
		logic [OCC_WORDS*OCC_WORD_W-1:0] ra;
		logic [OCC_WORDS*OCC_WORD_W-1:0] rb;
		logic [OCC_WORDS*OCC_WORD_W-1:0] rc;
		start = errors;
		a = random_task(F_RUN);
		b = random_task(F_RUN);
		c = random_task(F_RUN);
		submit(a);
		submit_done();
		repeat (12) begin	// held at the ring head, no response yet
			@(negedge Clk_32UI);
			check_val("out_status", 64'(out_status), 64'(BUBBLE));
		end
		send_rsp(ra);
		wait_out("task A", 40);
		check_task(a, ram_mem[a.qread][a.qpos], ra, 1'b1);
		send_rsp(rb);
		send_rsp(rc);
		submit(b);
		submit(c);
		submit_done();
		wait_out("task B", 40);
		check_task(b, ram_mem[b.qread][b.qpos], rb, 1'b1);
		wait_out("task C", 40);
		check_task(c, ram_mem[c.qread][c.qpos], rc, 1'b1);
		report_test("counted task", start);
	endtask

	task automatic test_stall();
		int start;
		task_rec_t d;
		task_status_e held;
		logic [OCC_WORDS*OCC_WORD_W-1:0] rd;
		start = errors;
		d = random_task(F_RUN);
		@(posedge Clk_32UI);
		stall          <= 1'b1;
		new_read_valid <= 1'b1;	// queues empty, only stall blocks it
		@(negedge Clk_32UI);
		held = out_status;
		check_val("new_read", 64'(new_read), 64'(1'b0));
		send_rsp(rd);
		repeat (4) begin
			@(negedge Clk_32UI);
			check_val("out_status", 64'(out_status), 64'(held));
			check_val("new_read", 64'(new_read), 64'(1'b0));
		end
		@(posedge Clk_32UI);
		stall          <= 1'b0;
		new_read_valid <= 1'b0;
		submit(d);
		submit_done();
		wait_out("task after stall", 40);
		check_task(d, ram_mem[d.qread][d.qpos], rd, 1'b1);
		report_test("stall", start);
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		int total;
		void'($urandom(32'hc72b_2ca5));
		for (int r = 0; r < (1 << READ_NUM_W); r++) begin
			for (int p = 0; p < (1 << POS_W); p++) begin
				ram_mem[r][p] = BASE_W'($urandom);
			end
		end
		reset_n             = 1'b0;
		stall               = 1'b0;
		in_status           = BUBBLE;
		ptr_curr            = '0;
		read_num            = '0;
		ik_x0               = '0;
		ik_x1               = '0;
		ik_x2               = '0;
		ik_info             = '0;
		forward_i           = '0;
		min_intv            = '0;
		backward_x          = '0;
		next_query_position = '0;
		read_num_query      = '0;
		dram_get            = 1'b0;
		occ_a0              = '0;
		occ_a1              = '0;
		occ_a2              = '0;
		occ_a3              = '0;
		new_read_valid      = 1'b0;
		new_read_num        = '0;
		new_ik_x0           = '0;
		new_ik_x1           = '0;
		new_ik_x2           = '0;
		new_ik_info         = '0;
		new_forward_i       = '0;
		new_min_intv        = '0;
		repeat (10) @(posedge Clk_32UI);
		reset_n <= 1'b1;

		test_reset();
		test_new_read();
		test_break();
		test_counted();
		test_stall();

		repeat (5) @(posedge Clk_32UI);	// let the last assertions sample
		total = errors + dut.u_props.assert_fails;
		$display("tests %0d, checks %0d, check errors %0d, assertion failures %0d",
			tests, checks, errors, dut.u_props.assert_fails);
		if (total == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: run.sh
#!/bin/sh
# build and run the seed queue testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module seed_queue_tb -f tb.f -o seed_queue_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# keep running past assertion errors so the testbench prints its verdict
./obj_dir/seed_queue_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
	exit 1
fi
exit 0

// File: src/occ_response_fifo.sv
module occ_response_fifo import seed_queue_pkg::*; (
	input  logic                  Clk_32UI,
	input  logic                  reset_n,
	input  logic                  dram_get,
	input  logic                  occ_pop,
	input  logic [OCC_WORD_W-1:0] occ_a0,
	input  logic [OCC_WORD_W-1:0] occ_a1,
	input  logic [OCC_WORD_W-1:0] occ_a2,
	input  logic [OCC_WORD_W-1:0] occ_a3,
	output logic                  occ_valid,
	output logic [OCC_WORD_W-1:0] occ_head0,
	output logic [OCC_WORD_W-1:0] occ_head1,
	output logic [OCC_WORD_W-1:0] occ_head2,
	output logic [OCC_WORD_W-1:0] occ_head3
);

	logic [OCC_WORDS*OCC_WORD_W-1:0] occ_mem [OCC_DEPTH];
	logic [OCC_PTR_W:0]              wr_ptr;	// extra wrap bit so all 8 slots fill
	logic [OCC_PTR_W:0]              rd_ptr;

	assign occ_valid = (wr_ptr != rd_ptr);

	// DRAM has no ready, so a pulse is taken even under stall
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (dram_get) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (occ_pop && occ_valid) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (dram_get) begin
			occ_mem[wr_ptr[OCC_PTR_W-1:0]] <= {occ_a0, occ_a1, occ_a2, occ_a3};
		end
	end

	assign {occ_head0, occ_head1, occ_head2, occ_head3} = occ_mem[rd_ptr[OCC_PTR_W-1:0]];

endmodule

// File: src/query_delay_line.sv
module query_delay_line import seed_queue_pkg::*; (
	input  logic                  Clk_32UI,
	input  logic                  reset_n,
	input  logic                  stall,
	input  task_status_e          in_status,
	input  logic [POS_W-1:0]      ptr_curr,
	input  logic [READ_NUM_W-1:0] read_num,
	input  logic [INTV_W-1:0]     ik_x0,
	input  logic [INTV_W-1:0]     ik_x1,
	input  logic [INTV_W-1:0]     ik_x2,
	input  logic [INFO_W-1:0]     ik_info,
	input  logic [POS_W-1:0]      forward_i,
	input  logic [POS_W-1:0]      min_intv,
	input  logic [POS_W-1:0]      backward_x,
	input  logic [BASE_W-1:0]     query_base,
	output logic                  ring_write,
	output logic [TASK_W-1:0]     ring_record
);

	task_status_e                status_d [QUERY_LAT];
	logic [STAGE_W-1:0]          fields_d [QUERY_LAT];
	task_status_e                rec_status;	// fourth register
	logic [TASK_W-STATUS_W-1:0]  rec_body;

	// status chain
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			for (int i = 0; i < QUERY_LAT; i++) begin
				status_d[i] <= BUBBLE;
			end
			rec_status <= BUBBLE;
		end else if (!stall) begin
			status_d[0] <= in_status;
			for (int i = 1; i < QUERY_LAT; i++) begin
				status_d[i] <= status_d[i-1];
			end
			rec_status <= status_d[QUERY_LAT-1];
		end
	end

	// payload waits here while the RAM looks up the base
	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			fields_d[0] <= {ptr_curr, read_num, ik_x0, ik_x1, ik_x2, ik_info,
				forward_i, min_intv, backward_x};
			for (int i = 1; i < QUERY_LAT; i++) begin
				fields_d[i] <= fields_d[i-1];
			end
			// base goes between min_intv and backward_x
			rec_body <= {fields_d[QUERY_LAT-1][STAGE_W-1:POS_W], query_base,
				fields_d[QUERY_LAT-1][POS_W-1:0]};
		end
	end

	assign ring_write  = (rec_status != BUBBLE);
	assign ring_record = {rec_body, rec_status};

endmodule

// File: src/seed_queue_pkg.sv
package seed_queue_pkg;

	// ==================================================
	// widths and depths
	// ==================================================
	localparam int STATUS_W   = 6;
	localparam int READ_NUM_W = 4;
	localparam int MAX_READ   = 8;	// reads in flight

	localparam int RING_DEPTH = 2 * MAX_READ;
	localparam int RING_PTR_W = 5;	// msb is the wrap bit
	localparam int OCC_DEPTH  = MAX_READ;
	localparam int OCC_PTR_W  = 3;	// index bits, wrap bit added on top

	localparam int POS_W      = 7;
	localparam int INTV_W     = 33;	// kept low bits of an interval word
	localparam int INFO_W     = 14;	// 7-bit high and 7-bit low info fields
	localparam int BASE_W     = 8;
	localparam int OCC_WORD_W = 32;
	localparam int OCC_WORDS  = 4;

	localparam int QUERY_LAT  = 3;	// read-base RAM latency, unstalled cycles

	// task fields carried down the delay line, no base and no status
	localparam int STAGE_W = POS_W		// ptr_curr
		+ READ_NUM_W
		+ 3 * INTV_W			// ik_x0..ik_x2
		+ INFO_W
		+ POS_W				// forward_i
		+ POS_W				// min_intv
		+ POS_W;			// backward_x

	// full ring record
	localparam int TASK_W = STAGE_W + BASE_W + STATUS_W;

	// ==================================================
	// task status
	// ==================================================
	typedef enum logic [STATUS_W-1:0] {
		BUBBLE  = 6'd0,
		F_INIT  = 6'd1,
		F_RUN   = 6'd2,
		F_BREAK = 6'd3
	} task_status_e;

endpackage

// File: src/seed_queue_top.sv
module seed_queue_top import seed_queue_pkg::*; (
	input  logic                  Clk_32UI,
	input  logic                  reset_n,
	input  logic                  stall,
	// pipeline side
	input  task_status_e          in_status,
	input  logic [POS_W-1:0]      ptr_curr,
	input  logic [READ_NUM_W-1:0] read_num,
	input  logic [INTV_W-1:0]     ik_x0,
	input  logic [INTV_W-1:0]     ik_x1,
	input  logic [INTV_W-1:0]     ik_x2,
	input  logic [INFO_W-1:0]     ik_info,
	input  logic [POS_W-1:0]      forward_i,
	input  logic [POS_W-1:0]      min_intv,
	input  logic [POS_W-1:0]      backward_x,
	input  logic [POS_W-1:0]      next_query_position,
	input  logic [READ_NUM_W-1:0] read_num_query,
	// read-base RAM
	output logic [POS_W-1:0]      query_position,
	output logic [READ_NUM_W-1:0] query_read_num,
	input  logic [BASE_W-1:0]     query_base,
	// DRAM count responses
	input  logic                  dram_get,
	input  logic [OCC_WORD_W-1:0] occ_a0,
	input  logic [OCC_WORD_W-1:0] occ_a1,
	input  logic [OCC_WORD_W-1:0] occ_a2,
	input  logic [OCC_WORD_W-1:0] occ_a3,
	// new read source
	output logic                  new_read,
	input  logic                  new_read_valid,
	input  logic [READ_NUM_W-1:0] new_read_num,
	input  logic [INTV_W-1:0]     new_ik_x0,
	input  logic [INTV_W-1:0]     new_ik_x1,
	input  logic [INTV_W-1:0]     new_ik_x2,
	input  logic [INFO_W-1:0]     new_ik_info,
	input  logic [POS_W-1:0]      new_forward_i,
	input  logic [POS_W-1:0]      new_min_intv,
	// back to the pipeline
	output task_status_e          out_status,
	output logic [POS_W-1:0]      out_ptr_curr,
	output logic [READ_NUM_W-1:0] out_read_num,
	output logic [INTV_W-1:0]     out_ik_x0,
	output logic [INTV_W-1:0]     out_ik_x1,
	output logic [INTV_W-1:0]     out_ik_x2,
	output logic [INFO_W-1:0]     out_ik_info,
	output logic [POS_W-1:0]      out_forward_i,
	output logic [POS_W-1:0]      out_min_intv,
	output logic [POS_W-1:0]      out_backward_x,
	output logic [BASE_W-1:0]     out_query,
	output logic [OCC_WORD_W-1:0] out_occ0,
	output logic [OCC_WORD_W-1:0] out_occ1,
	output logic [OCC_WORD_W-1:0] out_occ2,
	output logic [OCC_WORD_W-1:0] out_occ3
);

	logic                  ring_write;
	logic [TASK_W-1:0]     ring_record;
	logic                  ring_pop;
	task_status_e          head_status;
	logic [TASK_W-1:0]     head_record;
	logic                  occ_valid;
	logic                  occ_pop;
	logic [OCC_WORD_W-1:0] occ_head0;
	logic [OCC_WORD_W-1:0] occ_head1;
	logic [OCC_WORD_W-1:0] occ_head2;
	logic [OCC_WORD_W-1:0] occ_head3;

	// ==================================================
	// query request and new-read handshake
	// ==================================================
	assign query_position = next_query_position;	// forward side only
	assign query_read_num = read_num_query;

	// ring-empty term keeps this in step with the dispatcher's init branch
	assign new_read = new_read_valid && !occ_valid && !stall && (head_status == BUBBLE);

	query_delay_line u_delay (
		.Clk_32UI    (Clk_32UI),
		.reset_n     (reset_n),
		.stall       (stall),
		.in_status   (in_status),
		.ptr_curr    (ptr_curr),
		.read_num    (read_num),
		.ik_x0       (ik_x0),
		.ik_x1       (ik_x1),
		.ik_x2       (ik_x2),
		.ik_info     (ik_info),
		.forward_i   (forward_i),
		.min_intv    (min_intv),
		.backward_x  (backward_x),
		.query_base  (query_base),
		.ring_write  (ring_write),
		.ring_record (ring_record)
	);

	task_ring u_ring (
		.Clk_32UI    (Clk_32UI),
		.reset_n     (reset_n),
		.stall       (stall),
		.ring_write  (ring_write),
		.ring_pop    (ring_pop),
		.ring_record (ring_record),
		.head_status (head_status),
		.head_record (head_record)
	);

	occ_response_fifo u_occ (
		.Clk_32UI  (Clk_32UI),
		.reset_n   (reset_n),
		.dram_get  (dram_get),
		.occ_pop   (occ_pop),
		.occ_a0    (occ_a0),
		.occ_a1    (occ_a1),
		.occ_a2    (occ_a2),
		.occ_a3    (occ_a3),
		.occ_valid (occ_valid),
		.occ_head0 (occ_head0),
		.occ_head1 (occ_head1),
		.occ_head2 (occ_head2),
		.occ_head3 (occ_head3)
	);

	task_dispatch u_dispatch (
		.Clk_32UI       (Clk_32UI),
		.reset_n        (reset_n),
		.stall          (stall),
		.occ_valid      (occ_valid),
		.new_read_valid (new_read_valid),
		.head_status    (head_status),
		.head_record    (head_record),
		.occ_head0      (occ_head0),
		.occ_head1      (occ_head1),
		.occ_head2      (occ_head2),
		.occ_head3      (occ_head3),
		.new_read_num   (new_read_num),
		.new_ik_x0      (new_ik_x0),
		.new_ik_x1      (new_ik_x1),
		.new_ik_x2      (new_ik_x2),
		.new_ik_info    (new_ik_info),
		.new_forward_i  (new_forward_i),
		.new_min_intv   (new_min_intv),
		.ring_pop       (ring_pop),
		.occ_pop        (occ_pop),
		.out_status     (out_status),
		.out_ptr_curr   (out_ptr_curr),
		.out_forward_i  (out_forward_i),
		.out_min_intv   (out_min_intv),
		.out_backward_x (out_backward_x),
		.out_read_num   (out_read_num),
		.out_ik_x0      (out_ik_x0),
		.out_ik_x1      (out_ik_x1),
		.out_ik_x2      (out_ik_x2),
		.out_ik_info    (out_ik_info),
		.out_query      (out_query),
		.out_occ0       (out_occ0),
		.out_occ1       (out_occ1),
		.out_occ2       (out_occ2),
		.out_occ3       (out_occ3)
	);

endmodule

// File: src/task_dispatch.sv
module task_dispatch import seed_queue_pkg::*; (
	input  logic                  Clk_32UI,
	input  logic                  reset_n,
	input  logic                  stall,
	input  logic                  occ_valid,
	input  logic                  new_read_valid,
	input  task_status_e          head_status,
	input  logic [TASK_W-1:0]     head_record,
	input  logic [OCC_WORD_W-1:0] occ_head0,
	input  logic [OCC_WORD_W-1:0] occ_head1,
	input  logic [OCC_WORD_W-1:0] occ_head2,
	input  logic [OCC_WORD_W-1:0] occ_head3,
	input  logic [READ_NUM_W-1:0] new_read_num,
	input  logic [INTV_W-1:0]     new_ik_x0,
	input  logic [INTV_W-1:0]     new_ik_x1,
	input  logic [INTV_W-1:0]     new_ik_x2,
	input  logic [INFO_W-1:0]     new_ik_info,
	input  logic [POS_W-1:0]      new_forward_i,
	input  logic [POS_W-1:0]      new_min_intv,
	output logic                  ring_pop,
	output logic                  occ_pop,
	output task_status_e          out_status,
	output logic [POS_W-1:0]      out_ptr_curr,
	output logic [POS_W-1:0]      out_forward_i,
	output logic [POS_W-1:0]      out_min_intv,
	output logic [POS_W-1:0]      out_backward_x,
	output logic [READ_NUM_W-1:0] out_read_num,
	output logic [INTV_W-1:0]     out_ik_x0,
	output logic [INTV_W-1:0]     out_ik_x1,
	output logic [INTV_W-1:0]     out_ik_x2,
	output logic [INFO_W-1:0]     out_ik_info,
	output logic [BASE_W-1:0]     out_query,
	output logic [OCC_WORD_W-1:0] out_occ0,
	output logic [OCC_WORD_W-1:0] out_occ1,
	output logic [OCC_WORD_W-1:0] out_occ2,
	output logic [OCC_WORD_W-1:0] out_occ3
);

	logic [POS_W-1:0]      h_ptr_curr;
	logic [READ_NUM_W-1:0] h_read_num;
	logic [INTV_W-1:0]     h_ik_x0;
	logic [INTV_W-1:0]     h_ik_x1;
	logic [INTV_W-1:0]     h_ik_x2;
	logic [INFO_W-1:0]     h_ik_info;
	logic [POS_W-1:0]      h_forward_i;
	logic [POS_W-1:0]      h_min_intv;
	logic [BASE_W-1:0]     h_query;
	logic [POS_W-1:0]      h_backward_x;
	logic [STATUS_W-1:0]   h_status;
	logic                  take_break;
	logic                  take_count;
	logic                  take_new;

	// same field order as the delay line packs it
	assign {h_ptr_curr, h_read_num, h_ik_x0, h_ik_x1, h_ik_x2, h_ik_info,
		h_forward_i, h_min_intv, h_query, h_backward_x, h_status} = head_record;

	// ==================================================
	// priority: break, counted task, new read, bubble
	// ==================================================
	assign take_break = (head_status == F_BREAK);
	assign take_count = (head_status != BUBBLE) && !take_break && occ_valid;
	assign take_new   = (head_status == BUBBLE) && !occ_valid && new_read_valid;

	assign ring_pop = !stall && (take_break || take_count);
	assign occ_pop  = !stall && take_count;

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			out_status <= BUBBLE;
		end else if (!stall) begin
			if (take_break || take_count) begin
				out_status <= task_status_e'(h_status);
			end else if (take_new) begin
				out_status <= F_INIT;
			end else begin
				out_status <= BUBBLE;
			end
		end
	end

	// payload holds through bubbles
	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			if (take_break || take_count) begin
				out_ptr_curr   <= h_ptr_curr;
				out_read_num   <= h_read_num;
				out_ik_x0      <= h_ik_x0;
				out_ik_x1      <= h_ik_x1;
				out_ik_x2      <= h_ik_x2;
				out_ik_info    <= h_ik_info;
				out_forward_i  <= h_forward_i;
				out_min_intv   <= h_min_intv;
				out_query      <= h_query;
				out_backward_x <= h_backward_x;
			end else if (take_new) begin
				out_ptr_curr   <= '0;
				out_read_num   <= new_read_num;
				out_ik_x0      <= new_ik_x0;
				out_ik_x1      <= new_ik_x1;
				out_ik_x2      <= new_ik_x2;
				out_ik_info    <= new_ik_info;
				out_forward_i  <= new_forward_i + POS_W'(1);
				out_min_intv   <= new_min_intv;
				out_query      <= '0;	// first round needs no base
				out_backward_x <= new_forward_i;
			end
			if (take_count) begin
				out_occ0 <= occ_head0;
				out_occ1 <= occ_head1;
				out_occ2 <= occ_head2;
				out_occ3 <= occ_head3;
			end
		end
	end

endmodule

// File: src/task_ring.sv
module task_ring import seed_queue_pkg::*; (
	input  logic              Clk_32UI,
	input  logic              reset_n,
	input  logic              stall,
	input  logic              ring_write,
	input  logic              ring_pop,
	input  logic [TASK_W-1:0] ring_record,
	output task_status_e      head_status,
	output logic [TASK_W-1:0] head_record
);

	logic [TASK_W-1:0]     rec_mem    [RING_DEPTH];
	task_status_e          status_mem [RING_DEPTH];	// separate copy for head lookahead
	logic [RING_PTR_W-1:0] wr_ptr;
	logic [RING_PTR_W-1:0] rd_ptr;
	logic                  ring_empty;
	logic                  do_write;

	assign do_write   = ring_write && !stall;
	assign ring_empty = (wr_ptr == rd_ptr);	// wrap bits equal too

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (ring_pop && !ring_empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (do_write) begin
			rec_mem[wr_ptr[RING_PTR_W-2:0]]    <= ring_record;
			status_mem[wr_ptr[RING_PTR_W-2:0]] <= task_status_e'(ring_record[STATUS_W-1:0]);
		end
	end

	assign head_status = ring_empty ? BUBBLE : status_mem[rd_ptr[RING_PTR_W-2:0]];
	assign head_record = rec_mem[rd_ptr[RING_PTR_W-2:0]];

endmodule

// File: tb.f
src/seed_queue_pkg.sv
src/query_delay_line.sv
src/task_ring.sv
src/occ_response_fifo.sv
src/task_dispatch.sv
src/seed_queue_top.sv
dv/seed_queue_properties.sv
dv/seed_queue_tb.sv
